// ==== sources.f ====
+incdir+rtl
rtl/sweepCtrlPkg.sv
rtl/sweepFramePkg.sv
rtl/acqStepIf.sv
rtl/sweepController.sv
rtl/packageCounter.sv
rtl/acqFrameFormatter.sv
rtl/sweepAcqTop.sv
sim/sweepAcq_sva.sv
sim/sweepAcqTb.sv

// ==== Makefile ====
TOP       ?= sweepAcqTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/sweepAcqTb.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

module sweepAcqTb
  import sweepFramePkg::*;
();

  localparam int numSweeps  = 10;
  localparam int maxSteps   = 6;
  localparam int maxLimit   = 12;
  // Load, loader delay, header, words with up to two idle cycles each, step end
  localparam int stepCycles = 1 + 9 + 1 + 3 * (maxLimit + 1) + 3;
  localparam int cycleLimit = 8 + 20 + numSweeps * (maxSteps * stepCycles + 12);

  logic                    clk;
  logic                    reset_n;
  logic                    sweepStart;
  logic                    configDone;
  logic                    parallelDataEn;
  logic [`DAC_WIDTH-1:0]   startDac;
  logic [`DAC_WIDTH-1:0]   endDac;
  logic [`COUNT_WIDTH-1:0] maxPackageNumber;
  logic [`DATA_WIDTH-1:0]  parallelData;
  logic [`DAC_WIDTH-1:0]   outDac;
  logic                    loadScParameter;
  logic                    singleAcqStart;
  logic                    acqDone;
  logic [`DATA_WIDTH-1:0]  sweepAcqData;
  logic                    sweepAcqDataEn;

  // Reference model state
  logic [`DATA_WIDTH-1:0]  expWords[$];
  bit                      expIsHeader[$];
  logic [`DATA_WIDTH-1:0]  expWord;
  bit                      expHeader;
  int                      modelCode;
  int                      modelLimit;
  int                      expectedLoads;
  int                      loadsSeen;
  int                      stepWords;
  int                      cycleCount;
  int                      loadWait;
  int                      gapLeft;
  bit                      sweepActive;
  bit                      configSeen;

  sweepAcqTop i_dut (
    .clk              (clk),
    .reset_n          (reset_n),
    .sweepStart       (sweepStart),
    .configDone       (configDone),
    .parallelDataEn   (parallelDataEn),
    .startDac         (startDac),
    .endDac           (endDac),
    .maxPackageNumber (maxPackageNumber),
    .parallelData     (parallelData),
    .outDac           (outDac),
    .loadScParameter  (loadScParameter),
    .singleAcqStart   (singleAcqStart),
    .acqDone          (acqDone),
    .sweepAcqData     (sweepAcqData),
    .sweepAcqDataEn   (sweepAcqDataEn)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stopOnError(input string what);
    $display("FAILED at time %0t: %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // Loader answers each load request after 1 to 8 cycles
  always @(posedge clk) begin
    configDone <= 1'b0;
    if (loadScParameter) begin
      loadWait = int'($urandom_range(8, 1));
    end else if (loadWait > 0) begin
      loadWait = loadWait - 1;
      if (loadWait == 0) begin
        configDone <= 1'b1;
      end
    end
  end

  // ASIC readout keeps sending past the limit until the start level falls
  always @(posedge clk) begin
    parallelDataEn <= 1'b0;
    if (singleAcqStart) begin
      if (gapLeft == 0) begin
        parallelDataEn <= 1'b1;
        parallelData   <= 16'($urandom);
        gapLeft = int'($urandom_range(2, 0));
      end else begin
        gapLeft = gapLeft - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the sweeps did not finish within %0d cycles", cycleLimit);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  // Monitor and scoreboard
  always @(posedge clk) begin
    if (!sweepActive) begin
      assert (!loadScParameter && !singleAcqStart && !acqDone && !sweepAcqDataEn)
        else stopOnError("DUT active while no sweep is running");
    end
    if (configDone) begin
      configSeen = 1'b1;
    end
    if (sweepAcqDataEn) begin
      assert (expWords.size() > 0) else stopOnError("output word with nothing expected");
      expWord   = expWords.pop_front();
      expHeader = expIsHeader.pop_front();
      assert (sweepAcqData == expWord)
        else stopOnError($sformatf("output %h, expected %h", sweepAcqData, expWord));
      if (expHeader) begin
        assert (configSeen) else stopOnError("header word before configDone");
      end
    end
    if (loadScParameter) begin
      assert (outDac == modelCode[`DAC_WIDTH-1:0])
        else stopOnError($sformatf("outDac %0d, expected %0d", outDac, modelCode));
      assert (loadsSeen < expectedLoads) else stopOnError("more load requests than codes");
      expWords.push_back({headerTag, modelCode[`DAC_WIDTH-1:0]});
      expIsHeader.push_back(1'b1);
      modelCode  = modelCode + 1;
      loadsSeen  = loadsSeen + 1;
      stepWords  = 0;
      configSeen = 1'b0;
    end
    if (singleAcqStart && parallelDataEn && stepWords < modelLimit) begin
      expWords.push_back(parallelData);
      expIsHeader.push_back(1'b0);
      stepWords = stepWords + 1;
    end
    if (acqDone) begin
      assert (loadsSeen == expectedLoads)
        else stopOnError($sformatf("%0d loads, expected %0d", loadsSeen, expectedLoads));
      assert (expWords.size() == 0) else stopOnError("acqDone before the last data word");
      sweepActive <= 1'b0;
    end
  end

  task automatic runSweep(input int idx);
    int startCode;
    int span;
    int limit;
    startCode = int'($urandom_range(1000, 8));
    span      = int'($urandom_range(7, 0)) - 2;
    limit     = int'($urandom_range(maxLimit, 0));
    if (idx == 1) begin
      limit = 0;
    end
    if (idx == 2) begin
      span = -2;
    end
    // Reversed range sweeps the start code only
    modelCode     = startCode;
    modelLimit    = limit;
    expectedLoads = (span < 0) ? 1 : span + 1;
    loadsSeen     = 0;
    @(posedge clk);
    startDac         <= startCode[`DAC_WIDTH-1:0];
    endDac           <= 10'(startCode + span);
    maxPackageNumber <= limit[`COUNT_WIDTH-1:0];
    sweepStart       <= 1'b1;
    sweepActive      <= 1'b1;
    @(posedge clk);
    sweepStart <= 1'b0;
    repeat (2) @(posedge clk);
    // Start request while busy with a different range
    sweepStart <= 1'b1;
    startDac   <= 10'($urandom);
    endDac     <= 10'($urandom);
    @(posedge clk);
    sweepStart <= 1'b0;
    while (sweepActive) @(posedge clk);
  endtask

  initial begin
    void'($urandom(32'h632c785b));
    reset_n          = 1'b0;
    sweepStart       = 1'b0;
    configDone       = 1'b0;
    parallelDataEn   = 1'b0;
    startDac         = '0;
    endDac           = '0;
    maxPackageNumber = '0;
    parallelData     = '0;
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int i = 0; i < numSweeps; i++) begin
      runSweep(i);
    end
    repeat (5) @(posedge clk);
    if (i_dut.i_sva.svaErrors == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", i_dut.i_sva.svaErrors);
      $display("Simulation finished: FAIL");
      $fatal(1, "protocol assertion failures");
    end
  end

endmodule

// ==== sim/sweepAcq_sva.sv ====
`timescale 1ns/10ps

module sweepAcq_sva
  import sweepCtrlPkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input logic       loadScParameter,
  input logic       acqDone,
  input logic       singleAcqStart,
  input logic       sweepAcqDataEn,
  input sweepStateT ctrlState
);

  int svaErrors = 0;

  loadPulse: assert property (
    @(posedge clk) disable iff (!reset_n) loadScParameter |=> !loadScParameter
  ) else begin
    $error("loadScParameter high for more than one cycle");
    svaErrors++;
  end

  donePulse: assert property (
    @(posedge clk) disable iff (!reset_n) acqDone |=> !acqDone
  ) else begin
    $error("acqDone high for more than one cycle");
    svaErrors++;
  end

  // Acquisition opens together with the header word on the output
  acqAfterHeader: assert property (
    @(posedge clk) disable iff (!reset_n) $rose(singleAcqStart) |-> sweepAcqDataEn
  ) else begin
    $error("singleAcqStart rose without a header strobe");
    svaErrors++;
  end

  quietInConfig: assert property (
    @(posedge clk) disable iff (!reset_n) (ctrlState == waitConfig) |-> !sweepAcqDataEn
  ) else begin
    $error("output strobe while waiting for configDone");
    svaErrors++;
  end

endmodule

bind sweepAcqTop sweepAcq_sva i_sva (
  .clk             (clk),
  .reset_n         (reset_n),
  .loadScParameter (loadScParameter),
  .acqDone         (acqDone),
  .singleAcqStart  (singleAcqStart),
  .sweepAcqDataEn  (sweepAcqDataEn),
  .ctrlState       (i_controller.state)
);

// ==== rtl/sweepAcqTop.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

module sweepAcqTop (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    sweepStart,
  input  logic                    configDone,
  input  logic                    parallelDataEn,
  input  logic [`DAC_WIDTH-1:0]   startDac,
  input  logic [`DAC_WIDTH-1:0]   endDac,
  input  logic [`COUNT_WIDTH-1:0] maxPackageNumber,
  input  logic [`DATA_WIDTH-1:0]  parallelData,
  output logic [`DAC_WIDTH-1:0]   outDac,
  output logic                    loadScParameter,
  output logic                    singleAcqStart,
  output logic                    acqDone,
  output logic [`DATA_WIDTH-1:0]  sweepAcqData,
  output logic                    sweepAcqDataEn
);

  // Per-step handshake shared by the three blocks
  acqStepIf stepBus ();

  sweepController i_controller (
    .clk             (clk),
    .reset_n         (reset_n),
    .sweepStart      (sweepStart),
    .configDone      (configDone),
    .startDac        (startDac),
    .endDac          (endDac),
    .outDac          (outDac),
    .loadScParameter (loadScParameter),
    .singleAcqStart  (singleAcqStart),
    .acqDone         (acqDone),
    .step            (stepBus.ctrl)
  );

  packageCounter i_counter (
    .clk              (clk),
    .reset_n          (reset_n),
    .parallelDataEn   (parallelDataEn),
    .maxPackageNumber (maxPackageNumber),
    .step             (stepBus.counter)
  );

  acqFrameFormatter i_formatter (
    .clk            (clk),
    .reset_n        (reset_n),
    .parallelData   (parallelData),
    .sweepAcqData   (sweepAcqData),
    .sweepAcqDataEn (sweepAcqDataEn),
    .step           (stepBus.formatter)
  );

endmodule

// ==== rtl/acqFrameFormatter.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

module acqFrameFormatter
  import sweepFramePkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [`DATA_WIDTH-1:0] parallelData,
  output logic [`DATA_WIDTH-1:0] sweepAcqData,
  output logic                   sweepAcqDataEn,
  acqStepIf.formatter            step
);

  logic [`DATA_WIDTH-1:0] headerWord;

  // Tag on top, current threshold code below
  assign headerWord = {headerTag, step.dacCode};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sweepAcqDataEn <= 1'b0;
    end else begin
      sweepAcqDataEn <= step.headerReq || step.accept;
    end
  end

  // Header and accepted data never coincide
  always_ff @(posedge clk) begin
    if (step.headerReq) begin
      sweepAcqData <= headerWord;
    end else if (step.accept) begin
      sweepAcqData <= parallelData;
    end
  end

endmodule

// ==== rtl/packageCounter.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

module packageCounter (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    parallelDataEn,
  input  logic [`COUNT_WIDTH-1:0] maxPackageNumber,
  acqStepIf.counter               step
);

  logic [`COUNT_WIDTH-1:0] count;
  logic [`COUNT_WIDTH-1:0] countNext;
  logic                    completed;

  // Words past the limit are dropped
  assign step.accept = parallelDataEn && step.acquiring && (count < maxPackageNumber);

  assign countNext = count + {{(`COUNT_WIDTH-1){1'b0}}, step.accept};

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count         <= '0;
      step.stepDone <= 1'b0;
      completed     <= 1'b0;
    end else if (!step.acquiring) begin
      count         <= '0;
      step.stepDone <= 1'b0;
      completed     <= 1'b0;
    end else begin
      count <= countNext;
      // Single pulse per step, held off until acquiring drops
      step.stepDone <= (countNext >= maxPackageNumber) && !completed;
      if (countNext >= maxPackageNumber) begin
        completed <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/sweepController.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

module sweepController
  import sweepCtrlPkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  sweepStart,
  input  logic                  configDone,
  input  logic [`DAC_WIDTH-1:0] startDac,
  input  logic [`DAC_WIDTH-1:0] endDac,
  output logic [`DAC_WIDTH-1:0] outDac,
  output logic                  loadScParameter,
  output logic                  singleAcqStart,
  output logic                  acqDone,
  acqStepIf.ctrl                step
);

  sweepStateT            state;
  sweepStateT            nextState;
  logic [`DAC_WIDTH-1:0] dacCode;
  logic [`DAC_WIDTH-1:0] endCode;
  logic                  lastCode;

  // End code below start code also counts as last after the first step
  assign lastCode = (dacCode >= endCode);

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (sweepStart) begin
          nextState = load;
        end
      end
      load: begin
        nextState = waitConfig;
      end
      waitConfig: begin
        if (configDone) begin
          nextState = header;
        end
      end
      header: begin
        nextState = acquire;
      end
      acquire: begin
        if (step.stepDone) begin
          nextState = lastCode ? finish : load;
        end
      end
      finish: begin
        nextState = idle;
      end
      default: begin
        nextState = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // Sweep range latched at start, code advanced after each step
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dacCode <= '0;
      endCode <= '0;
    end else if (state == idle && sweepStart) begin
      dacCode <= startDac;
      endCode <= endDac;
    end else if (state == acquire && step.stepDone && !lastCode) begin
      dacCode <= dacCode + 1'b1;
    end
  end

  assign outDac       = dacCode;
  assign step.dacCode = dacCode;

  // Moore outputs
  assign loadScParameter = (state == load);
  assign step.headerReq  = (state == header);
  assign step.acquiring  = (state == acquire);
  assign singleAcqStart  = (state == acquire);
  assign acqDone         = (state == finish);

endmodule

// ==== rtl/acqStepIf.sv ====
`timescale 1ns/10ps
`include "sweepAcq_settings.svh"

interface acqStepIf;

  logic [`DAC_WIDTH-1:0] dacCode;
  logic                  headerReq;
  logic                  acquiring;
  logic                  accept;
  logic                  stepDone;

  modport ctrl (
    output dacCode,
    output headerReq,
    output acquiring,
    input  stepDone
  );

  modport counter (
    input  acquiring,
    output accept,
    output stepDone
  );

  modport formatter (
    input dacCode,
    input headerReq,
    input accept
  );

endinterface

// ==== rtl/sweepFramePkg.sv ====
package sweepFramePkg;

  // Header word: tag in the upper bits, DAC code below
  localparam int headerTagWidth = 6;

  localparam logic [headerTagWidth-1:0] headerTag = 6'b101101;

endpackage

// ==== rtl/sweepCtrlPkg.sv ====
package sweepCtrlPkg;

  // Sweep controller states
  typedef enum logic [2:0] {
    idle       = 3'd0,
    load       = 3'd1,
    waitConfig = 3'd2,
    header     = 3'd3,
    acquire    = 3'd4,
    finish     = 3'd5
  } sweepStateT;

endpackage

// ==== rtl/sweepAcq_settings.svh ====
`ifndef SWEEP_ACQ_SETTINGS_SVH
`define SWEEP_ACQ_SETTINGS_SVH

// DAC0 threshold code
`define DAC_WIDTH 10

// Readout words and output stream words
`define DATA_WIDTH 16

// Package limit and per-step package count
`define COUNT_WIDTH 16

`endif
